// ==== fifo_pkg.sv ====
// Shared word, level and register map definitions for the stream FIFO.
package fifo_pkg;

    localparam int word_width = 32;                 // Payload bits per FIFO entry.
    localparam int addr_width = 8;                  // Storage address bits.
    localparam int depth = 1 << addr_width;         // Number of storage entries.
    localparam int level_width = addr_width + 1;    // Wide enough to count a full FIFO.

    typedef logic [word_width-1:0] word_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [level_width-1:0] level_t;

    // Register bus data, unused upper bits read back as zero.
    typedef logic [31:0] csr_data_t;

    typedef enum logic [1:0] {
        CSR_CTRL   = 2'd0,  // Bit 0 requests a flush.
        CSR_THRESH = 2'd1,  // Almost-full threshold.
        CSR_LEVEL  = 2'd2,  // Current fill level, read only.
        CSR_PEAK   = 2'd3   // High-water mark, a write reloads it.
    } csr_addr_e;

    localparam int thresh_width = level_width;      // Threshold covers the whole level range.
    localparam level_t thresh_reset = level_t'(192);
    localparam int flush_bit = 0;                   // Position of the flush command in CSR_CTRL.

endpackage

// ==== bram.sv ====
// Block RAM built from narrow synchronous blocks tiled across the word width.
`timescale 1ns/1ps

module bram_block #(
    parameter int read_after_write = 0,
    parameter int addr_width = 8,
    parameter int data_width = 16
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] waddr,
    input  logic [addr_width-1:0] raddr,
    input  logic [data_width-1:0] wdata,
    input  logic                  write_enable,
    output logic [data_width-1:0] rdata
);

    logic [data_width-1:0] mem [(1 << addr_width)-1:0];

    // Start from a known state so the first reads are not X in simulation.
    initial begin
        for (int i = 0; i < (1 << addr_width); i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[waddr] <= wdata;
        end
    end

    generate
        if (read_after_write != 0) begin : g_bypass
            logic                  hit_q;    // Last read collided with a write.
            logic [data_width-1:0] bypass_q;
            logic [addr_width-1:0] raddr_q;

            always_ff @(posedge clk) begin
                hit_q <= write_enable && (raddr == waddr);
                raddr_q <= raddr;
                if (write_enable) begin
                    bypass_q <= wdata;
                end
            end

            assign rdata = hit_q ? bypass_q : mem[raddr_q];
        end else begin : g_plain
            always_ff @(posedge clk) begin
                rdata <= mem[raddr];    // Old data on a same-address collision.
            end
        end
    endgenerate

endmodule

module bram #(
    parameter int read_after_write = 0,
    parameter int blocks = 1,
    parameter int block_addr_width = 8,
    parameter int block_data_width = 16
) (
    input  logic                                 clk,
    input  logic [block_addr_width-1:0]          waddr,
    input  logic [block_addr_width-1:0]          raddr,
    input  logic [blocks*block_data_width-1:0]   wdata,
    input  logic [blocks-1:0]                    write_mask,
    output logic [blocks*block_data_width-1:0]   rdata
);

    generate
        for (genvar lane = 0; lane < blocks; lane++) begin : g_lane
            bram_block #(
                .read_after_write(read_after_write),
                .addr_width(block_addr_width),
                .data_width(block_data_width)
            ) u_block (
                .clk(clk),
                .waddr(waddr),
                .raddr(raddr),
                .wdata(wdata[lane*block_data_width +: block_data_width]),
                .write_enable(write_mask[lane]),
                .rdata(rdata[lane*block_data_width +: block_data_width])
            );
        end
    endgenerate

endmodule

// ==== fifo_ctrl.sv ====
// FIFO controller with pointer logic, BRAM read pipeline and a two-entry output skid buffer.
`timescale 1ns/1ps

module fifo_ctrl #(
    parameter int blocks = 2,
    parameter int block_addr_width = 8,
    parameter int block_data_width = 16,
    parameter int read_after_write = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  fifo_pkg::word_t        in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fifo_pkg::word_t        out_data,
    input  logic                   flush,
    output fifo_pkg::level_t       level,
    output logic                   push,
    output logic                   pop
);

    localparam fifo_pkg::level_t full_level = fifo_pkg::level_t'(fifo_pkg::depth);

    fifo_pkg::addr_t  wptr_q;
    fifo_pkg::addr_t  rptr_q;
    fifo_pkg::level_t stored_q;      // Words still held in the BRAM.
    fifo_pkg::level_t level_q;
    fifo_pkg::level_t level_next;
    logic             ready_q;
    logic             rd_issue;
    logic             rd_pending_q;  // BRAM read data arrives this cycle.
    logic             skid_room;
    logic [1:0]       skid_count_q;
    fifo_pkg::word_t  skid_q [2];
    fifo_pkg::word_t  bram_rdata;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;
    assign in_ready = ready_q && !flush;
    assign out_valid = skid_count_q != 2'd0;
    assign out_data = skid_q[0];
    assign level = level_q;

    // A read may start when the skid buffer can take it one cycle after the in-flight word.
    assign skid_room = ((skid_count_q + 2'(rd_pending_q)) != 2'd2) || pop;
    assign rd_issue = !flush && (stored_q != '0) && skid_room;

    always_comb begin
        if (flush) begin
            level_next = '0;
        end else begin
            level_next = level_q + fifo_pkg::level_t'(push) - fifo_pkg::level_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wptr_q <= '0;
            rptr_q <= '0;
            stored_q <= '0;
            rd_pending_q <= 1'b0;
            skid_count_q <= '0;
        end else begin
            wptr_q <= wptr_q + fifo_pkg::addr_t'(push);
            rptr_q <= rptr_q + fifo_pkg::addr_t'(rd_issue);
            stored_q <= stored_q + fifo_pkg::level_t'(push) - fifo_pkg::level_t'(rd_issue);
            rd_pending_q <= rd_issue;
            skid_count_q <= skid_count_q + 2'(rd_pending_q) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_q <= '0;
            ready_q <= 1'b0;
        end else begin
            level_q <= level_next;
            ready_q <= level_next != full_level;    // Input closes once the FIFO is full.
        end
    end

    // The head entry shifts forward on a pop and the arriving word fills the first free slot.
    always_ff @(posedge clk) begin
        if (pop) begin
            skid_q[0] <= (skid_count_q == 2'd1) ? bram_rdata : skid_q[1];
        end else if (rd_pending_q && skid_count_q == 2'd0) begin
            skid_q[0] <= bram_rdata;
        end
        if (rd_pending_q && (skid_count_q == 2'd2 || (skid_count_q == 2'd1 && !pop))) begin
            skid_q[1] <= bram_rdata;
        end
    end

    bram #(
        .read_after_write(read_after_write),
        .blocks(blocks),
        .block_addr_width(block_addr_width),
        .block_data_width(block_data_width)
    ) u_bram (
        .clk(clk),
        .waddr(wptr_q),
        .raddr(rptr_q),
        .wdata(in_data),
        .write_mask({blocks{push}}),  // Always a full-word write.
        .rdata(bram_rdata)
    );

    assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (stored_q + fifo_pkg::level_t'(rd_pending_q)
                  + fifo_pkg::level_t'(skid_count_q)) != full_level);
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> level_q != '0);
    assert property (@(posedge clk) disable iff (!rst_n) level_q <= full_level);
    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_data)));

endmodule

// ==== fifo_csr.sv ====
// Register block holding the almost-full threshold, flush command and high-water mark.
`timescale 1ns/1ps

module fifo_csr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   csr_valid,
    output logic                   csr_ready,
    input  logic                   csr_write,
    input  fifo_pkg::csr_addr_e    csr_addr,
    input  fifo_pkg::csr_data_t    csr_wdata,
    output logic                   csr_rvalid,
    output fifo_pkg::csr_data_t    csr_rdata,
    input  fifo_pkg::level_t       level,
    output logic                   flush,
    output logic                   almost_full
);

    fifo_pkg::level_t thresh_q;
    fifo_pkg::level_t peak_q;
    logic             write_req;
    logic             read_req;

    assign csr_ready = 1'b1;    // Every request is taken at once.
    assign write_req = csr_valid && csr_ready && csr_write;
    assign read_req = csr_valid && csr_ready && !csr_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            thresh_q <= fifo_pkg::thresh_reset;
            peak_q <= '0;
            flush <= 1'b0;
            almost_full <= 1'b0;
            csr_rvalid <= 1'b0;
        end else begin
            flush <= write_req && (csr_addr == fifo_pkg::CSR_CTRL)
                     && csr_wdata[fifo_pkg::flush_bit];
            if (write_req && csr_addr == fifo_pkg::CSR_THRESH) begin
                thresh_q <= csr_wdata[fifo_pkg::thresh_width-1:0];
            end
            if (write_req && csr_addr == fifo_pkg::CSR_PEAK) begin
                peak_q <= level;    // Restart tracking from the present level.
            end else if (level > peak_q) begin
                peak_q <= level;
            end
            almost_full <= level >= thresh_q;
            csr_rvalid <= read_req;
        end
    end

    // Read data is captured from the addressed register.
    always_ff @(posedge clk) begin
        if (read_req) begin
            unique case (csr_addr)
                fifo_pkg::CSR_CTRL:   csr_rdata <= '0;
                fifo_pkg::CSR_THRESH: csr_rdata <= fifo_pkg::csr_data_t'(thresh_q);
                fifo_pkg::CSR_LEVEL:  csr_rdata <= fifo_pkg::csr_data_t'(level);
                fifo_pkg::CSR_PEAK:   csr_rdata <= fifo_pkg::csr_data_t'(peak_q);
                default:              csr_rdata <= '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) flush |=> !flush);

endmodule

// ==== stream_fifo.sv ====
// Stream FIFO top level joining the controller, its BRAM and the register block.
`timescale 1ns/1ps

module stream_fifo #(
    parameter int blocks = 2,
    parameter int block_data_width = 16,
    parameter int block_addr_width = 8,
    parameter int read_after_write = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  fifo_pkg::word_t        in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output fifo_pkg::word_t        out_data,
    input  logic                   csr_valid,
    output logic                   csr_ready,
    input  logic                   csr_write,
    input  fifo_pkg::csr_addr_e    csr_addr,
    input  fifo_pkg::csr_data_t    csr_wdata,
    output logic                   csr_rvalid,
    output fifo_pkg::csr_data_t    csr_rdata,
    output logic                   almost_full
);

    fifo_pkg::level_t level;
    logic             flush;

    // The lanes must exactly cover one word and the pointers must match the storage depth.
    if (blocks * block_data_width != $bits(fifo_pkg::word_t)) begin : g_width_check
        $error("BRAM lanes do not add up to the FIFO word width");
    end
    if (block_addr_width != $bits(fifo_pkg::addr_t)) begin : g_depth_check
        $error("BRAM address width does not match the FIFO depth");
    end

    fifo_ctrl #(
        .blocks(blocks),
        .block_addr_width(block_addr_width),
        .block_data_width(block_data_width),
        .read_after_write(read_after_write)
    ) u_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .flush(flush),
        .level(level),
        .push(),
        .pop()
    );

    fifo_csr u_csr (
        .clk(clk),
        .rst_n(rst_n),
        .csr_valid(csr_valid),
        .csr_ready(csr_ready),
        .csr_write(csr_write),
        .csr_addr(csr_addr),
        .csr_wdata(csr_wdata),
        .csr_rvalid(csr_rvalid),
        .csr_rdata(csr_rdata),
        .level(level),
        .flush(flush),
        .almost_full(almost_full)
    );

endmodule

// ==== tb_stream_fifo.sv ====
// Testbench for the stream FIFO, driven by a case file with random stalls on both streams.
`timescale 1ns/1ps

module tb_stream_fifo;

    localparam int clk_half = 20;    // 40 ns clock period.

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic                 in_ready;
    fifo_pkg::word_t      in_data;
    logic                 out_valid;
    logic                 out_ready;
    fifo_pkg::word_t      out_data;
    logic                 csr_valid;
    logic                 csr_ready;
    logic                 csr_write;
    fifo_pkg::csr_addr_e  csr_addr;
    fifo_pkg::csr_data_t  csr_wdata;
    logic                 csr_rvalid;
    fifo_pkg::csr_data_t  csr_rdata;
    logic                 almost_full;

    bit [31:0]            lfsr_q = 32'hdf4c173a;
    fifo_pkg::word_t      ref_q [$];     // Words accepted and not yet popped.
    byte                  case_op [$];
    int                   case_arg [$];
    fifo_pkg::word_t      case_val [$];
    int                   total_ops;
    bit                   cases_loaded;

    stream_fifo dut (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .csr_valid(csr_valid),
        .csr_ready(csr_ready),
        .csr_write(csr_write),
        .csr_addr(csr_addr),
        .csr_wdata(csr_wdata),
        .csr_rvalid(csr_rvalid),
        .csr_rdata(csr_rdata),
        .almost_full(almost_full)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per stall bit.
    function automatic bit draw_stall();
        bit feedback;
        feedback = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], feedback};
        return feedback;
    endfunction

    task automatic check_word(fifo_pkg::word_t got, fifo_pkg::word_t exp, string what);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_level(fifo_pkg::level_t got, fifo_pkg::level_t exp, string what);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_csr(fifo_pkg::csr_data_t got, fifo_pkg::csr_data_t exp, string what);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(bit got, bit exp, string what);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic load_cases();
        int fd;
        int fields;
        int arg;
        string line;
        string op;
        fifo_pkg::word_t val;
        fd = $fopen("fifo_cases.txt", "r");
        if (fd == 0) begin
            stop_with_error("Could not open the case file fifo_cases.txt for reading.");
        end
        total_ops = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%s %d %h", op, arg, val);
            if (fields == 3 && op[0] != "#") begin
                case_op.push_back(op[0]);
                case_arg.push_back(arg);
                case_val.push_back(val);
                total_ops += (op[0] == "P" || op[0] == "O" || op[0] == "I") ? arg : 1;
            end
        end
        $fclose(fd);
    endtask

    task automatic push_words(int count, fifo_pkg::word_t first);
        for (int i = 0; i < count; i++) begin
            while (draw_stall()) begin
                in_valid = 1'b0;    // Random gap in the input stream.
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_data = first + fifo_pkg::word_t'(i);
            while (!in_ready) @(negedge clk);
            @(negedge clk);    // The word transferred on the rising edge just passed.
            ref_q.push_back(first + fifo_pkg::word_t'(i));
        end
        in_valid = 1'b0;
    endtask

    task automatic pop_words(int count, fifo_pkg::word_t first);
        fifo_pkg::word_t got;
        fifo_pkg::word_t exp;
        for (int i = 0; i < count; i++) begin
            while (draw_stall()) begin
                out_ready = 1'b0;    // Back-pressure on a random cycle.
                @(negedge clk);
            end
            out_ready = 1'b1;
            while (!out_valid) @(negedge clk);
            got = out_data;
            @(negedge clk);
            if (ref_q.size() == 0) begin
                stop_with_error("A word came out while the reference queue was empty.");
            end
            exp = ref_q.pop_front();
            check_word(got, exp, "popped word");
            if (i == 0) begin
                check_word(exp, first, "first expected word from the case file");
            end
        end
        out_ready = 1'b0;
    endtask

    task automatic write_csr(int addr, fifo_pkg::csr_data_t data);
        csr_valid = 1'b1;
        csr_write = 1'b1;
        csr_addr = fifo_pkg::csr_addr_e'(addr);
        csr_wdata = data;
        check_flag(csr_ready, 1'b1, "csr_ready");
        @(negedge clk);
        csr_valid = 1'b0;
        csr_write = 1'b0;
    endtask

    task automatic read_and_check(int addr, fifo_pkg::csr_data_t exp);
        fifo_pkg::csr_data_t data;
        csr_valid = 1'b1;
        csr_write = 1'b0;
        csr_addr = fifo_pkg::csr_addr_e'(addr);
        @(negedge clk);
        check_flag(csr_rvalid, 1'b1, "csr_rvalid after a read");
        data = csr_rdata;
        csr_valid = 1'b0;
        if (addr == fifo_pkg::CSR_LEVEL || addr == fifo_pkg::CSR_PEAK) begin
            check_level(fifo_pkg::level_t'(data), fifo_pkg::level_t'(exp), "register level");
            check_csr(data >> $bits(fifo_pkg::level_t), '0, "unused register bits");
        end else begin
            check_csr(data, exp, "register read");
        end
    endtask

    task automatic expect_flag(int sel, bit exp);
        case (sel)
            0: check_flag(almost_full, exp, "almost_full");
            1: check_flag(in_ready, exp, "in_ready");
            2: check_flag(out_valid, exp, "out_valid");
            default: stop_with_error($sformatf("Case file asks for unknown flag %0d.", sel));
        endcase
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        csr_valid = 1'b0;
        csr_write = 1'b0;
        csr_addr = fifo_pkg::CSR_CTRL;
        csr_wdata = '0;
        load_cases();
        cases_loaded = 1'b1;
        repeat (2) @(negedge clk);    // Two rising edges with reset low.
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < case_op.size(); i++) begin
            case (case_op[i])
                "P": push_words(case_arg[i], case_val[i]);
                "O": pop_words(case_arg[i], case_val[i]);
                "W": begin
                    write_csr(case_arg[i], case_val[i]);
                    if (case_arg[i] == fifo_pkg::CSR_CTRL && case_val[i][fifo_pkg::flush_bit]) begin
                        ref_q.delete();    // A flush drops every stored word.
                    end
                end
                "R": read_and_check(case_arg[i], case_val[i]);
                "F": expect_flag(case_arg[i], case_val[i][0]);
                "I": repeat (case_arg[i]) @(negedge clk);
                default: stop_with_error($sformatf("Unknown operation on case line %0d.", i));
            endcase
        end
        $display("Finished with no errors");
        $finish;
    end

    // The limit grows with the number of words and idle cycles in the case file.
    initial begin
        wait (cases_loaded);
        repeat (64 * total_ops + 600) @(posedge clk);
        stop_with_error("Timeout: the cases did not complete in the allowed number of cycles.");
    end

endmodule

// ==== fifo_cases.txt ====
# Columns: op, count or register address (decimal), value (hex), one operation per line.
# P pushes count words from value upward, O pops count words whose first is value,
# W and R write and read a register, F checks a flag (0 almost_full, 1 in_ready,
# 2 out_valid) against value, I idles for count cycles.
R 1 000000c0
W 3 00000000
P 100 00010000
O 60 00010000
P 120 00020000
O 90 0001003c
P 80 00030000
O 150 00020032
R 3 000000a0
P 25 00040000
O 7 00040000
I 2 00000000
R 2 00000012
W 1 0000000a
O 9 00040007
I 1 00000000
F 0 00000000
P 1 00050000
I 1 00000000
F 0 00000001
W 3 00000000
R 3 0000000a
O 10 00040010
R 3 0000000a
P 256 00060000
F 1 00000000
I 4 00000000
F 1 00000000
R 2 00000100
O 256 00060000
P 5 00070000
W 0 00000001
I 2 00000000
F 2 00000000
R 2 00000000
P 1 00080000
O 1 00080000

// ==== project.f ====
fifo_pkg.sv
bram.sv
fifo_ctrl.sv
fifo_csr.sv
stream_fifo.sv
tb_stream_fifo.sv

// ==== Bender.yml ====
package:
  name: stream_fifo

sources:
  - fifo_pkg.sv
  - bram.sv
  - fifo_ctrl.sv
  - fifo_csr.sv
  - stream_fifo.sv
  - target: test
    files:
      - tb_stream_fifo.sv
